// File: rtl/wbdown_pkg.sv
/*
 * Shared definitions for the 64 to 32 bit Wishbone down-converter.
 * Bus widths, beat ratio, ack FIFO depth, vector types and the
 * narrow cycle FSM state encoding.
 */

package wbdown_pkg;

	////////////////////////////////////////
	// Bus geometry
	localparam int ADDRESS_WIDTH = 28;
	localparam int WIDE_DW = 64;
	localparam int SMALL_DW = 32;
	localparam int WIDE_SW = WIDE_DW / 8;
	localparam int SMALL_SW = SMALL_DW / 8;

	// Every wide request becomes this many narrow beats
	localparam int BEAT_RATIO = WIDE_DW / SMALL_DW;
	localparam int WBLSB = $clog2(BEAT_RATIO);

	// Word address widths of the two ports
	localparam int WIDE_AW = ADDRESS_WIDTH - $clog2(WIDE_SW);
	localparam int SMALL_AW = ADDRESS_WIDTH - $clog2(SMALL_SW);

	// Last-beat flag FIFO
	localparam int LGFIFO = 5;
	localparam int ACK_FIFO_DEPTH = 1 << LGFIFO;

	////////////////////////////////////////
	// Types
	typedef logic [WIDE_AW-1:0] wide_addr_t;
	typedef logic [SMALL_AW-1:0] small_addr_t;
	typedef logic [WIDE_DW-1:0] wide_data_t;
	typedef logic [SMALL_DW-1:0] small_data_t;
	typedef logic [WIDE_SW-1:0] wide_sel_t;
	typedef logic [SMALL_SW-1:0] small_sel_t;
	typedef logic [$clog2(BEAT_RATIO+1)-1:0] beat_cnt_t;
	typedef logic [LGFIFO:0] fill_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_OPEN,
		ST_SPLIT
	} cyc_state_t;

endpackage

// File: rtl/wbdown_cycle_fsm.sv
/*
 * Narrow bus cycle FSM.
 * Decides when a wide request is accepted and when the cycle aborts.
 */

`timescale 1ns/1ps

module wbdown_cycle_fsm (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_wcyc,
	input  logic i_wstb,
	input  logic i_stall_out,
	input  logic i_serr,
	input  logic i_werr,
	input  logic i_last_taken,
	output logic o_scyc,
	output logic o_accept,
	output logic o_abort
);

	wbdown_pkg::cyc_state_t state;

	// Wide master gone, slave error, or error still being reported
	assign o_abort = !i_wcyc || (o_scyc && i_serr) || i_werr;

	assign o_accept = i_wcyc && i_wstb && !i_stall_out && !o_abort;

	assign o_scyc = (state != wbdown_pkg::ST_IDLE);

	always_ff @(posedge i_clk)
	begin
		if (i_rst || o_abort)
			state <= wbdown_pkg::ST_IDLE;
		else
		begin
			case (state)
				wbdown_pkg::ST_IDLE:
					if (o_accept)
						state <= wbdown_pkg::ST_SPLIT;
				wbdown_pkg::ST_SPLIT:
					// A new request may land on the last beat's edge
					if (i_last_taken && !o_accept)
						state <= wbdown_pkg::ST_OPEN;
				wbdown_pkg::ST_OPEN:
					if (o_accept)
						state <= wbdown_pkg::ST_SPLIT;
				default:
					state <= wbdown_pkg::ST_IDLE;
			endcase
		end
	end

	// The last beat only ever ends a request that is being split
	a_last_in_split: assert property (
		@(posedge i_clk) disable iff (i_rst)
		i_last_taken |-> (state == wbdown_pkg::ST_SPLIT)
	);

endmodule

// File: rtl/wbdown_beat_counter.sv
/*
 * Count of narrow beats still to issue for the current wide request.
 */

`timescale 1ns/1ps

module wbdown_beat_counter (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_abort,
	input  logic i_accept,
	input  logic i_beat_take,
	output logic o_pending,
	output logic o_last_beat,
	output logic o_busy
);

	wbdown_pkg::beat_cnt_t count;

	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_abort)
			count <= '0;
		else if (i_accept)
			count <= wbdown_pkg::beat_cnt_t'(wbdown_pkg::BEAT_RATIO);
		else if (i_beat_take)
			count <= count - 1'b1;
	end

	assign o_pending = (count != '0);
	assign o_last_beat = (count == wbdown_pkg::beat_cnt_t'(1));
	assign o_busy = (count > wbdown_pkg::beat_cnt_t'(1));

	a_count_range: assert property (
		@(posedge i_clk) disable iff (i_rst)
		count <= wbdown_pkg::beat_cnt_t'(wbdown_pkg::BEAT_RATIO)
	);

endmodule

// File: rtl/wbdown_req_shifter.sv
/*
 * Wide request holding register.
 * Presents the upper narrow word as the current beat, big-endian order.
 */

`timescale 1ns/1ps

module wbdown_req_shifter (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_abort,
	input  logic i_accept,
	input  logic i_beat_take,
	input  logic i_we,
	input  wbdown_pkg::wide_addr_t i_waddr,
	input  wbdown_pkg::wide_data_t i_wdata,
	input  wbdown_pkg::wide_sel_t i_wsel,
	output logic o_swe,
	output wbdown_pkg::small_addr_t o_saddr,
	output wbdown_pkg::small_data_t o_sdata,
	output wbdown_pkg::small_sel_t o_ssel
);

	wbdown_pkg::small_addr_t r_addr;
	wbdown_pkg::wide_data_t s_data;
	wbdown_pkg::wide_sel_t s_sel;
	logic r_we;

	// Direction and address
	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_abort)
		begin
			r_we <= 1'b0;
			r_addr <= '0;
		end
		else if (i_accept)
		begin
			r_we <= i_we;
			r_addr <= {i_waddr, {wbdown_pkg::WBLSB{1'b0}}};
		end
		else if (i_beat_take)
			r_addr[wbdown_pkg::WBLSB-1:0] <= r_addr[wbdown_pkg::WBLSB-1:0] + 1'b1;
	end

	// Payload shifts up one narrow word per beat
	always_ff @(posedge i_clk)
	begin
		if (i_accept)
		begin
			s_data <= i_wdata;
			s_sel <= i_wsel;
		end
		else if (i_beat_take)
		begin
			s_data <= s_data << wbdown_pkg::SMALL_DW;
			s_sel <= s_sel << wbdown_pkg::SMALL_SW;
		end
	end

	assign o_swe = r_we;
	assign o_saddr = r_addr;
	assign o_sdata = s_data[wbdown_pkg::WIDE_DW-1 -: wbdown_pkg::SMALL_DW];
	assign o_ssel = s_sel[wbdown_pkg::WIDE_SW-1 -: wbdown_pkg::SMALL_SW];

endmodule

// File: rtl/wbdown_ack_fifo.sv
/*
 * Last-beat flag FIFO, one entry per issued narrow beat.
 * Reads through the input flag when empty.
 */

`timescale 1ns/1ps

module wbdown_ack_fifo (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_abort,
	input  logic i_push,
	input  logic i_last,
	input  logic i_pop,
	output logic o_full,
	output logic o_head_last
);

	logic flags [0:wbdown_pkg::ACK_FIFO_DEPTH-1];
	logic [wbdown_pkg::LGFIFO-1:0] wr_ptr;
	logic [wbdown_pkg::LGFIFO-1:0] rd_ptr;
	wbdown_pkg::fill_t fill;
	logic empty;

	assign empty = (fill == '0);
	assign o_full = (fill == wbdown_pkg::fill_t'(wbdown_pkg::ACK_FIFO_DEPTH));

	always_ff @(posedge i_clk)
	begin
		if (i_push)
			flags[wr_ptr] <= i_last;
	end

	////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_abort)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Ack in the same cycle as its own beat
	assign o_head_last = empty ? i_last : flags[rd_ptr];

	// Every narrow ack must match a beat that was issued
	a_no_pop_empty: assert property (
		@(posedge i_clk) disable iff (i_rst || i_abort)
		(i_pop && empty) |-> i_push
	);

endmodule

// File: rtl/wbdown_resp_gather.sv
/*
 * Response side: gathers narrow read words into one wide word
 * and produces the wide ack and error.
 */

`timescale 1ns/1ps

module wbdown_resp_gather (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_wcyc,
	input  logic i_scyc,
	input  logic i_sack,
	input  logic i_serr,
	input  logic i_head_last,
	input  wbdown_pkg::small_data_t i_sdata,
	output wbdown_pkg::wide_data_t o_wdata,
	output logic o_wack,
	output logic o_werr
);

	wbdown_pkg::wide_data_t r_data;
	logic r_ack;
	logic r_err;
	logic active;

	assign active = i_wcyc && i_scyc;

	// Even word arrives first, so it ends up in the upper half
	always_ff @(posedge i_clk)
	begin
		if (!active)
			r_data <= '0;
		else if (i_sack)
			r_data <= {r_data[wbdown_pkg::WIDE_DW-wbdown_pkg::SMALL_DW-1:0], i_sdata};
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst || !active)
		begin
			r_ack <= 1'b0;
			r_err <= 1'b0;
		end
		else
		begin
			r_ack <= i_sack && i_head_last;
			r_err <= i_serr;
		end
	end

	assign o_wdata = r_data;
	assign o_wack = r_ack;
	assign o_werr = r_err;

endmodule

// File: rtl/wbdown_top.sv
/*
 * Wishbone 64 to 32 bit down-converter, top level.
 * Connects cycle FSM, beat counter, request shifter, ack FIFO
 * and response gather, and forms strobe and stall.
 */

`timescale 1ns/1ps

module wbdown_top (
	input  logic i_clk,
	input  logic i_rst,
	// Wide slave port
	input  logic i_wcyc,
	input  logic i_wstb,
	input  logic i_wwe,
	input  wbdown_pkg::wide_addr_t i_waddr,
	input  wbdown_pkg::wide_data_t i_wdata,
	input  wbdown_pkg::wide_sel_t i_wsel,
	output logic o_wstall,
	output logic o_wack,
	output wbdown_pkg::wide_data_t o_wdata,
	output logic o_werr,
	// Narrow master port
	output logic o_scyc,
	output logic o_sstb,
	output logic o_swe,
	output wbdown_pkg::small_addr_t o_saddr,
	output wbdown_pkg::small_data_t o_sdata,
	output wbdown_pkg::small_sel_t o_ssel,
	input  logic i_sstall,
	input  logic i_sack,
	input  wbdown_pkg::small_data_t i_sdata,
	input  logic i_serr
);

	logic accept;
	logic abort;
	logic pending;
	logic last_beat;
	logic busy;
	logic beat_take;
	logic last_taken;
	logic fifo_full;
	logic head_last;

	////////////////////////////////////////
	// Handshake glue
	assign o_sstb = pending && !fifo_full;
	assign beat_take = pending && !fifo_full && !i_sstall;
	assign last_taken = beat_take && last_beat;

	// Held while a beat waits, or while more than one beat remains
	assign o_wstall = (pending && (fifo_full || i_sstall)) || busy;

	wbdown_cycle_fsm u_fsm (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_wcyc       (i_wcyc),
		.i_wstb       (i_wstb),
		.i_stall_out  (o_wstall),
		.i_serr       (i_serr),
		.i_werr       (o_werr),
		.i_last_taken (last_taken),
		.o_scyc       (o_scyc),
		.o_accept     (accept),
		.o_abort      (abort)
	);

	wbdown_beat_counter u_count (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_abort     (abort),
		.i_accept    (accept),
		.i_beat_take (beat_take),
		.o_pending   (pending),
		.o_last_beat (last_beat),
		.o_busy      (busy)
	);

	wbdown_req_shifter u_shift (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_abort     (abort),
		.i_accept    (accept),
		.i_beat_take (beat_take),
		.i_we        (i_wwe),
		.i_waddr     (i_waddr),
		.i_wdata     (i_wdata),
		.i_wsel      (i_wsel),
		.o_swe       (o_swe),
		.o_saddr     (o_saddr),
		.o_sdata     (o_sdata),
		.o_ssel      (o_ssel)
	);

	wbdown_ack_fifo u_fifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_abort     (abort),
		.i_push      (beat_take),
		.i_last      (last_beat),
		.i_pop       (i_sack),
		.o_full      (fifo_full),
		.o_head_last (head_last)
	);

	wbdown_resp_gather u_gather (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wcyc      (i_wcyc),
		.i_scyc      (o_scyc),
		.i_sack      (i_sack),
		.i_serr      (i_serr),
		.i_head_last (head_last),
		.i_sdata     (i_sdata),
		.o_wdata     (o_wdata),
		.o_wack      (o_wack),
		.o_werr      (o_werr)
	);

	// Beats only go out inside a narrow cycle
	a_stb_in_cyc: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_sstb |-> o_scyc
	);

endmodule

// File: sim/tb_wbdown.sv
/*
 * Testbench for the 64 to 32 bit Wishbone down-converter.
 * Random wide master, narrow slave memory with random stall and ack
 * latency, and a reference model of the big-endian beat split.
 */

`timescale 1ns/1ps

module tb_wbdown;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_REQ = 40;
	localparam int TOTAL_REQ = 3 * NUM_REQ + 5;
	localparam int WATCHDOG_CYCLES = TOTAL_REQ * 40 + RESET_CYCLES;
	localparam int MEM_WORDS = 32;

	logic i_clk;
	logic i_rst;
	logic i_wcyc;
	logic i_wstb;
	logic i_wwe;
	wbdown_pkg::wide_addr_t i_waddr;
	wbdown_pkg::wide_data_t i_wdata;
	wbdown_pkg::wide_sel_t i_wsel;
	logic o_wstall;
	logic o_wack;
	wbdown_pkg::wide_data_t o_wdata;
	logic o_werr;
	logic o_scyc;
	logic o_sstb;
	logic o_swe;
	wbdown_pkg::small_addr_t o_saddr;
	wbdown_pkg::small_data_t o_sdata;
	wbdown_pkg::small_sel_t o_ssel;
	logic i_sstall;
	logic i_sack;
	wbdown_pkg::small_data_t i_sdata;
	logic i_serr;

	integer seed;
	int cycle;
	int errors;
	int test_errors;
	int n_accepted;
	int n_wack;
	int n_werr;
	int req_left;
	int write_pct;
	int last_due;
	logic inject_err;
	logic stb_taken;

	wbdown_pkg::small_data_t mem [0:MEM_WORDS-1];

	// Expected narrow beats, one entry per beat
	wbdown_pkg::small_addr_t exp_addr_q[$];
	wbdown_pkg::small_data_t exp_data_q[$];
	wbdown_pkg::small_sel_t exp_sel_q[$];
	logic exp_we_q[$];
	logic exp_last_q[$];

	// Slave responses still owed
	int rsp_due_q[$];
	wbdown_pkg::small_data_t rsp_data_q[$];
	logic rsp_last_q[$];
	logic rsp_we_q[$];

	// Slave response of this cycle and the wide response due next cycle
	logic sack_last_cur;
	logic sack_we_cur;
	logic serr_cur;
	wbdown_pkg::small_data_t rd_hi;
	wbdown_pkg::wide_data_t rdata_cur;
	logic wack_due;
	logic wack_we;
	logic werr_due;
	wbdown_pkg::wide_data_t rdata_due;

	wbdown_top dut (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wcyc   (i_wcyc),
		.i_wstb   (i_wstb),
		.i_wwe    (i_wwe),
		.i_waddr  (i_waddr),
		.i_wdata  (i_wdata),
		.i_wsel   (i_wsel),
		.o_wstall (o_wstall),
		.o_wack   (o_wack),
		.o_wdata  (o_wdata),
		.o_werr   (o_werr),
		.o_scyc   (o_scyc),
		.o_sstb   (o_sstb),
		.o_swe    (o_swe),
		.o_saddr  (o_saddr),
		.o_sdata  (o_sdata),
		.o_ssel   (o_ssel),
		.i_sstall (i_sstall),
		.i_sack   (i_sack),
		.i_sdata  (i_sdata),
		.i_serr   (i_serr)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	task automatic report_mismatch(input string what);
		$display("Error at %0t ns: %s", $time, what);
		test_errors++;
	endtask

	////////////////////////////////////////
	// Narrow slave memory model

	task automatic take_beat();
		wbdown_pkg::small_addr_t addr;
		logic [4:0] idx;
		int due;
		assert (exp_addr_q.size() != 0)
		else
		begin
			$display("Narrow beat issued with no wide request outstanding");
			test_errors++;
		end
		if (exp_addr_q.size() == 0)
			return;
		addr = exp_addr_q[0];
		idx = addr[4:0];
		assert (o_saddr == addr)
		else
			report_mismatch($sformatf("beat address %h, expected %h", o_saddr, addr));
		assert (o_swe == exp_we_q[0])
		else
			report_mismatch($sformatf("beat we %b, expected %b", o_swe, exp_we_q[0]));
		assert (o_ssel == exp_sel_q[0])
		else
			report_mismatch($sformatf("beat sel %h, expected %h", o_ssel, exp_sel_q[0]));
		if (exp_we_q[0])
		begin
			assert (o_sdata == exp_data_q[0])
			else
				report_mismatch($sformatf("beat data %h, expected %h", o_sdata, exp_data_q[0]));
			for (int b = 0; b < wbdown_pkg::SMALL_SW; b++)
				if (exp_sel_q[0][b])
					mem[idx][8*b +: 8] = exp_data_q[0][8*b +: 8];
		end
		// In-order acks 1 to 4 cycles after the take and at most one per cycle
		if (!serr_cur)
		begin
			due = cycle + 1 + pick(4);
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			rsp_due_q.push_back(due);
			rsp_data_q.push_back(exp_we_q[0] ? '0 : mem[idx]);
			rsp_last_q.push_back(exp_last_q[0]);
			rsp_we_q.push_back(exp_we_q[0]);
		end
		void'(exp_addr_q.pop_front());
		void'(exp_data_q.pop_front());
		void'(exp_sel_q.pop_front());
		void'(exp_we_q.pop_front());
		void'(exp_last_q.pop_front());
	endtask

	task automatic flush_responses();
		rsp_due_q.delete();
		rsp_data_q.delete();
		rsp_last_q.delete();
		rsp_we_q.delete();
	endtask

	////////////////////////////////////////
	// Per-cycle sampling and driving

	// Sampled mid-cycle for the coming rising edge
	task automatic observe_edge();
		assert (o_wack == wack_due)
		else
			report_mismatch($sformatf("o_wack is %b, expected %b", o_wack, wack_due));
		assert (o_werr == werr_due)
		else
			report_mismatch($sformatf("o_werr is %b, expected %b", o_werr, werr_due));
		if (o_wack && wack_due && !wack_we)
		begin
			assert (o_wdata == rdata_due)
			else
				report_mismatch($sformatf("read data %h, expected %h", o_wdata, rdata_due));
		end
		if (o_werr)
		begin
			assert (!o_scyc)
			else
				report_mismatch("o_scyc still high while o_werr is reported");
		end
		n_wack += int'(o_wack);
		n_werr += int'(o_werr);
		wack_due = sack_last_cur;
		wack_we = sack_we_cur;
		rdata_due = rdata_cur;
		werr_due = serr_cur;
		if (o_sstb && !i_sstall)
			take_beat();
		// Big-endian split of an accepted request
		if (i_wcyc && i_wstb && !o_wstall)
		begin
			n_accepted++;
			stb_taken = 1'b1;
			exp_addr_q.push_back({i_waddr, 1'b0});
			exp_data_q.push_back(i_wdata[63:32]);
			exp_sel_q.push_back(i_wsel[7:4]);
			exp_we_q.push_back(i_wwe);
			exp_last_q.push_back(1'b0);
			exp_addr_q.push_back({i_waddr, 1'b1});
			exp_data_q.push_back(i_wdata[31:0]);
			exp_sel_q.push_back(i_wsel[3:0]);
			exp_we_q.push_back(i_wwe);
			exp_last_q.push_back(1'b1);
		end
	endtask

	task automatic drive_cycle();
		// Slave drops all state when the narrow cycle ends
		if (!o_scyc)
		begin
			flush_responses();
			exp_addr_q.delete();
			exp_data_q.delete();
			exp_sel_q.delete();
			exp_we_q.delete();
			exp_last_q.delete();
		end
		i_sack = 1'b0;
		i_serr = 1'b0;
		i_sdata = '0;
		sack_last_cur = 1'b0;
		serr_cur = 1'b0;
		if (rsp_due_q.size() != 0 && rsp_due_q[0] == cycle)
		begin
			if (inject_err)
			begin
				i_serr = 1'b1;
				serr_cur = 1'b1;
				inject_err = 1'b0;
				flush_responses();
			end
			else
			begin
				i_sack = 1'b1;
				i_sdata = rsp_data_q[0];
				if (rsp_last_q[0])
				begin
					sack_last_cur = 1'b1;
					sack_we_cur = rsp_we_q[0];
					rdata_cur = {rd_hi, rsp_data_q[0]};
				end
				else
					rd_hi = rsp_data_q[0];
				void'(rsp_due_q.pop_front());
				void'(rsp_data_q.pop_front());
				void'(rsp_last_q.pop_front());
				void'(rsp_we_q.pop_front());
			end
		end
		i_sstall = (pick(100) < 30);
		if (stb_taken)
		begin
			i_wstb = 1'b0;
			stb_taken = 1'b0;
		end
		if (i_wcyc && !i_wstb && req_left > 0 && pick(100) < 70)
		begin
			i_wstb = 1'b1;
			i_wwe = (pick(100) < write_pct);
			i_waddr = wbdown_pkg::wide_addr_t'($random(seed));
			i_wdata = {$random(seed), $random(seed)};
			i_wsel = wbdown_pkg::wide_sel_t'($random(seed));
			req_left--;
		end
	endtask

	task automatic run_cycle();
		@(negedge i_clk);
		observe_edge();
		@(posedge i_clk);
		cycle++;
		#(DRIVE_DELAY);
		drive_cycle();
	endtask

	////////////////////////////////////////
	// Tests

	task automatic check_reset_state();
		test_errors = 0;
		for (int i = 0; i < 6; i++)
		begin
			@(negedge i_clk);
			assert (!o_scyc && !o_sstb && !o_wstall && !o_wack && !o_werr)
			else
				report_mismatch($sformatf("after reset scyc=%b sstb=%b wstall=%b wack=%b werr=%b",
					o_scyc, o_sstb, o_wstall, o_wack, o_werr));
			@(posedge i_clk);
			#(DRIVE_DELAY);
			// Cycle open but no strobe yet
			if (i == 2)
				i_wcyc = 1'b1;
		end
		i_wcyc = 1'b0;
		$display("Test reset: %0d failures", test_errors);
		errors += test_errors;
	endtask

	task automatic run_test(input string name, input int count, input int wr_pct,
			input logic with_err);
		int expect_err;
		test_errors = 0;
		n_accepted = 0;
		n_wack = 0;
		n_werr = 0;
		req_left = count;
		write_pct = wr_pct;
		inject_err = with_err;
		expect_err = with_err ? 1 : 0;
		i_wcyc = 1'b1;
		while (req_left > 0 || i_wstb || exp_addr_q.size() != 0 || rsp_due_q.size() != 0)
			run_cycle();
		repeat (4)
			run_cycle();
		assert (n_werr == expect_err)
		else
			report_mismatch($sformatf("%0d error responses, expected %0d", n_werr, expect_err));
		assert (n_wack + n_werr == n_accepted)
		else
			report_mismatch($sformatf("%0d responses for %0d accepted requests",
				n_wack + n_werr, n_accepted));
		i_wcyc = 1'b0;
		repeat (2)
			run_cycle();
		$display("Test %s: %0d requests, %0d acks, %0d failures",
			name, n_accepted, n_wack, test_errors);
		errors += test_errors;
	endtask

	initial
	begin
		seed = 99858;
		cycle = 0;
		errors = 0;
		last_due = 0;
		inject_err = 1'b0;
		stb_taken = 1'b0;
		sack_last_cur = 1'b0;
		sack_we_cur = 1'b0;
		serr_cur = 1'b0;
		rd_hi = '0;
		rdata_cur = '0;
		wack_due = 1'b0;
		wack_we = 1'b0;
		werr_due = 1'b0;
		rdata_due = '0;
		i_rst = 1'b1;
		i_wcyc = 1'b0;
		i_wstb = 1'b0;
		i_wwe = 1'b0;
		i_waddr = '0;
		i_wdata = '0;
		i_wsel = '0;
		i_sstall = 1'b0;
		i_sack = 1'b0;
		i_sdata = '0;
		i_serr = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'h3c000000 ^ (32'(i) * 32'h00010101);
		repeat (RESET_CYCLES)
			@(posedge i_clk);
		#(DRIVE_DELAY);
		i_rst = 1'b0;
		check_reset_state();
		run_test("write split", NUM_REQ, 100, 1'b0);
		run_test("read gather", NUM_REQ, 0, 1'b0);
		run_test("pipelined mix", NUM_REQ, 50, 1'b0);
		run_test("slave error", 1, 50, 1'b1);
		run_test("after error", 4, 50, 1'b0);
		$display("Summary: 6 tests run, %0d failed checks", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge i_clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: wbdown_top.f
rtl/wbdown_pkg.sv
rtl/wbdown_cycle_fsm.sv
rtl/wbdown_beat_counter.sv
rtl/wbdown_req_shifter.sv
rtl/wbdown_ack_fifo.sv
rtl/wbdown_resp_gather.sv
rtl/wbdown_top.sv
sim/tb_wbdown.sv

// File: run.sh
#!/bin/sh
# Compile and run the down-converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_wbdown -f wbdown_top.f
if [ $? -ne 0 ]; then
	echo "Compile step failed"
	exit 1
fi

output=$(./obj_dir/Vtb_wbdown)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
